/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := ssa_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/ssa_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_allocator (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  ssa_pkg::flit_t                   flit_i [ssa_pkg::NUM_PORTS],
    input  wire logic [ssa_pkg::NUM_PORTS-1:0] flit_wr_i,
    input  wire logic [ssa_pkg::NUM_PORTS-1:0] any_ivc_sw_granted_i, // per input port
    input  wire logic [ssa_pkg::NUM_PORTS-1:0] any_ovc_granted_i,    // per output port
    input  ssa_pkg::vc_vec_t                 ovc_avail_i [ssa_pkg::NUM_PORTS],
    input  ssa_pkg::vc_vec_t                 ovc_full_i  [ssa_pkg::NUM_PORTS],
    input  ssa_pkg::ivc_info_t               ivc_info_i  [ssa_pkg::NUM_PORTS][ssa_pkg::NUM_VC],
    output ssa_pkg::ssa_ctrl_t               ssa_ctrl_o  [ssa_pkg::NUM_PORTS]
);

    import ssa_pkg::*;

    ssa_vc_evt_t evt [NUM_PORTS]; // per input port

    // input side, no bypass from the local port
    for (genvar c = 0; c < NUM_PORTS; c++) begin : g_in
        localparam port_idx_t SS = straight_port(port_idx_t'(c));

        if (port_idx_t'(c) == PORT_LOCAL) begin : g_local
            assign evt[c] = '0;
        end else begin : g_ssa
            ssa_in_port u_in_port (
                .flit_i               (flit_i[c]),
                .flit_wr_i            (flit_wr_i[c]),
                .any_ivc_sw_granted_i (any_ivc_sw_granted_i[c]),
                .ss_ovc_granted_i     (any_ovc_granted_i[SS]),
                .ss_ovc_avail_i       (ovc_avail_i[SS]),
                .ss_ovc_full_i        (ovc_full_i[SS]),
                .ss_port_i            (SS),
                .ivc_info_i           (ivc_info_i[c]),
                .evt_o                (evt[c])
            );
        end
    end

    // output side, each port is fed by its straight neighbour
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
        localparam port_idx_t SS = straight_port(port_idx_t'(p));

        ssa_vc_evt_t ss_evt;

        if (SS == PORT_NONE) begin : g_none
            assign ss_evt = '0;
        end else begin : g_feed
            assign ss_evt = evt[SS];
        end

        ssa_out_collect u_out_collect (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .in_evt_i (evt[p]),
            .ss_evt_i (ss_evt),
            .ctrl_o   (ssa_ctrl_o[p])
        );
    end

endmodule

`default_nettype wire

/* hdl/ssa_in_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_in_port (
    input  ssa_pkg::flit_t      flit_i,
    input  wire logic           flit_wr_i,
    input  wire logic           any_ivc_sw_granted_i, // normal path owns this input
    input  wire logic           ss_ovc_granted_i,     // normal path owns straight output
    input  ssa_pkg::vc_vec_t    ss_ovc_avail_i,
    input  ssa_pkg::vc_vec_t    ss_ovc_full_i,
    input  ssa_pkg::port_idx_t  ss_port_i,
    input  ssa_pkg::ivc_info_t  ivc_info_i [ssa_pkg::NUM_VC],
    output ssa_pkg::ssa_vc_evt_t evt_o
);

    import ssa_pkg::*;

    logic    port_free;
    logic    hdr_to_ss;
    vc_vec_t vc_wr;
    vc_vec_t sw_grant;
    vc_vec_t ovc_grant;
    vc_vec_t ivc_reset;
    vc_vec_t ovc_alloc;
    vc_vec_t ovc_release;
    vc_vec_t single_flit;

    assign port_free = ~(any_ivc_sw_granted_i | ss_ovc_granted_i);
    assign hdr_to_ss = (flit_i.dst_port == ss_port_i);
    assign vc_wr     = {NUM_VC{flit_wr_i}} & flit_i.vc;

    // one controller per input VC, all sharing the same flit
    for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
        ssa_vc_ctrl #(
            .VC_IDX(v)
        ) u_vc_ctrl (
            .vc_wr_i       (vc_wr[v]),
            .flit_i        (flit_i),
            .hdr_to_ss_i   (hdr_to_ss),
            .port_free_i   (port_free),
            .info_i        (ivc_info_i[v]),
            .ss_port_i     (ss_port_i),
            .ovc_avail_i   (ss_ovc_avail_i[v]),
            .ovc_full_i    (ss_ovc_full_i[v]),
            .sw_grant_o    (sw_grant[v]),
            .ovc_grant_o   (ovc_grant[v]),
            .ivc_reset_o   (ivc_reset[v]),
            .ovc_alloc_o   (ovc_alloc[v]),
            .ovc_release_o (ovc_release[v]),
            .single_flit_o (single_flit[v])
        );
    end

    assign evt_o = '{
        sw_grant:    sw_grant,
        ovc_grant:   ovc_grant,
        ivc_reset:   ivc_reset,
        ovc_alloc:   ovc_alloc,
        ovc_release: ovc_release,
        single_flit: single_flit
    };

endmodule

`default_nettype wire

/* hdl/ssa_out_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_out_collect (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  ssa_pkg::ssa_vc_evt_t in_evt_i, // from this port's input side
    input  ssa_pkg::ssa_vc_evt_t ss_evt_i, // from the input feeding this output
    output ssa_pkg::ssa_ctrl_t   ctrl_o
);

    import ssa_pkg::*;

    logic flit_wr_q;

    // bypassed flit lands in the output one cycle after its switch grant
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flit_wr_q <= 1'b0;
        end else begin
            flit_wr_q <= |ss_evt_i.sw_grant;
        end
    end

    always_comb begin
        ctrl_o = '0;

        // output VCs of this port, same index as the feeding input VC
        ctrl_o.ovc_is_allocated     = ss_evt_i.ovc_alloc;
        ctrl_o.ovc_is_released      = ss_evt_i.ovc_release;
        ctrl_o.buff_space_decreased = ss_evt_i.sw_grant;

        // input VCs of this port
        ctrl_o.ivc_num_getting_sw_grant  = in_evt_i.sw_grant;
        ctrl_o.ivc_num_getting_ovc_grant = in_evt_i.ovc_grant;
        ctrl_o.ivc_reset                 = in_evt_i.ivc_reset;
        ctrl_o.ivc_single_flit_pck       = in_evt_i.single_flit;

        // input vc v always gets output vc v
        for (int v = 0; v < NUM_VC; v++) begin
            ctrl_o.ivc_granted_ovc_num[v][v] = in_evt_i.ovc_grant[v];
        end

        ctrl_o.ssa_flit_wr = flit_wr_q;
    end

endmodule

`default_nettype wire

/* hdl/ssa_pkg.sv */
`default_nettype none

package ssa_pkg;

    // router shape, 2D mesh with one local port
    localparam int NUM_PORTS = 5;
    localparam int NUM_VC    = 2;
    localparam int PORT_W    = 3;
    localparam int PAYLOAD_W = 32;

    typedef logic [PORT_W-1:0] port_idx_t;
    typedef logic [NUM_VC-1:0] vc_vec_t;

    localparam port_idx_t PORT_LOCAL = port_idx_t'(0);
    localparam port_idx_t PORT_EAST  = port_idx_t'(1);
    localparam port_idx_t PORT_NORTH = port_idx_t'(2);
    localparam port_idx_t PORT_WEST  = port_idx_t'(3);
    localparam port_idx_t PORT_SOUTH = port_idx_t'(4);
    localparam port_idx_t PORT_NONE  = port_idx_t'(NUM_PORTS); // no straight port

    typedef struct packed {
        logic                 hdr;
        logic                 tail;
        vc_vec_t              vc;       // one-hot input VC
        port_idx_t            dst_port; // valid on header flits
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // buffered packet state of one input VC
    typedef struct packed {
        logic      ivc_req;         // VC already requesting the switch
        logic      ovc_is_assigned;
        vc_vec_t   assigned_ovc;
        port_idx_t dest_port;
    } ivc_info_t;

    // per-VC strobes of one input port
    typedef struct packed {
        vc_vec_t sw_grant;    // doubles as credit decrease
        vc_vec_t ovc_grant;
        vc_vec_t ivc_reset;
        vc_vec_t ovc_alloc;
        vc_vec_t ovc_release;
        vc_vec_t single_flit;
    } ssa_vc_evt_t;

    typedef struct packed {
        vc_vec_t                ovc_is_allocated;     // output side
        vc_vec_t                ovc_is_released;
        vc_vec_t                buff_space_decreased;
        vc_vec_t                ivc_num_getting_sw_grant;  // input side
        vc_vec_t                ivc_num_getting_ovc_grant;
        vc_vec_t                ivc_reset;
        vc_vec_t                ivc_single_flit_pck;
        vc_vec_t [NUM_VC-1:0]   ivc_granted_ovc_num;
        logic                   ssa_flit_wr;
    } ssa_ctrl_t;

    // east and west face each other, so do north and south
    function automatic port_idx_t straight_port(input port_idx_t p);
        case (p)
            PORT_EAST:  return PORT_WEST;
            PORT_WEST:  return PORT_EAST;
            PORT_NORTH: return PORT_SOUTH;
            PORT_SOUTH: return PORT_NORTH;
            default:    return PORT_NONE; // local port
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/ssa_vc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_vc_ctrl #(
    parameter int VC_IDX = 0
) (
    input  wire logic              vc_wr_i,     // flit written into this VC
    input  ssa_pkg::flit_t         flit_i,
    input  wire logic              hdr_to_ss_i, // header dest is the straight port
    input  wire logic              port_free_i,
    input  ssa_pkg::ivc_info_t     info_i,
    input  ssa_pkg::port_idx_t     ss_port_i,
    input  wire logic              ovc_avail_i,
    input  wire logic              ovc_full_i,
    output logic                   sw_grant_o,
    output logic                   ovc_grant_o,
    output logic                   ivc_reset_o,
    output logic                   ovc_alloc_o,
    output logic                   ovc_release_o,
    output logic                   single_flit_o
);

    logic single;
    logic asg_ready;
    logic ovc_ready;
    logic fire;
    logic credit_pre;
    logic alloc_pre;
    logic reset_pre;

    assign single = flit_i.hdr & flit_i.tail;

    // packet in flight must already be heading straight on the same ovc
    assign asg_ready = (info_i.dest_port == ss_port_i) &
                       info_i.assigned_ovc[VC_IDX] & ~ovc_full_i;
    assign ovc_ready = info_i.ovc_is_assigned ? asg_ready : ovc_avail_i;

    assign fire = vc_wr_i & ovc_ready & port_free_i & ~info_i.ivc_req;

    assign credit_pre = ~(flit_i.hdr & ~hdr_to_ss_i); // headers elsewhere excluded
    assign alloc_pre  = flit_i.hdr & hdr_to_ss_i;
    assign reset_pre  = single ? credit_pre : flit_i.tail;

    assign sw_grant_o    = fire & credit_pre;
    assign ovc_grant_o   = fire & alloc_pre;
    assign ivc_reset_o   = fire & reset_pre;

    // single-flit packets never hold the output VC
    assign ovc_alloc_o   = ovc_grant_o & ~single;
    assign ovc_release_o = ivc_reset_o & ~single;
    assign single_flit_o = fire & single;

endmodule

`default_nettype wire

/* verif/ssa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ssa_tb;

    import ssa_pkg::*;

    localparam int POLL_LIMIT = 40; // four clock periods of 2 ns polls

    logic                 clk;
    logic                 rst_n;
    flit_t                flit      [NUM_PORTS];
    logic [NUM_PORTS-1:0] flit_wr;
    logic [NUM_PORTS-1:0] sw_granted;
    logic [NUM_PORTS-1:0] ovc_granted;
    vc_vec_t              ovc_avail [NUM_PORTS];
    vc_vec_t              ovc_full  [NUM_PORTS];
    ivc_info_t            ivc_info  [NUM_PORTS][NUM_VC];
    ssa_ctrl_t            ssa_ctrl  [NUM_PORTS];

    logic [NUM_PORTS-1:0] flit_wr_exp; // from last cycle's sw grants
    int seed = 32'he5f9_faa9;
    int checks;
    int errors;
    int test_errors;

    ssa_allocator u_dut (
        .clk                  (clk),
        .rst_n_i              (rst_n),
        .flit_i               (flit),
        .flit_wr_i            (flit_wr),
        .any_ivc_sw_granted_i (sw_granted),
        .any_ovc_granted_i    (ovc_granted),
        .ovc_avail_i          (ovc_avail),
        .ovc_full_i           (ovc_full),
        .ivc_info_i           (ivc_info),
        .ssa_ctrl_o           (ssa_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // east/west and north/south face each other
    function automatic port_idx_t opposite_port(input int c);
        case (c)
            1:       return PORT_WEST;
            3:       return PORT_EAST;
            2:       return PORT_SOUTH;
            4:       return PORT_NORTH;
            default: return PORT_NONE;
        endcase
    endfunction

    // expected strobes of input port c
    function automatic ssa_vc_evt_t ref_evt(input int c);
        ssa_vc_evt_t e;
        port_idx_t   ss;
        ivc_info_t   info;
        logic        free;
        logic        ready;
        logic        single;
        logic        credit;
        logic        to_ss;
        e = '0;
        ss = opposite_port(c);
        if (ss == PORT_NONE) return e; // local port never bypasses
        free   = ~(sw_granted[c] | ovc_granted[ss]);
        to_ss  = (flit[c].dst_port == ss);
        single = flit[c].hdr & flit[c].tail;
        credit = ~flit[c].hdr | to_ss;
        for (int v = 0; v < NUM_VC; v++) begin
            info = ivc_info[c][v];
            if (info.ovc_is_assigned) begin
                ready = (info.dest_port == ss) && info.assigned_ovc[v] && !ovc_full[ss][v];
            end else begin
                ready = ovc_avail[ss][v];
            end
            if (flit_wr[c] && flit[c].vc[v] && ready && free && !info.ivc_req) begin
                e.sw_grant[v]    = credit;
                e.ovc_grant[v]   = flit[c].hdr & to_ss;
                e.ivc_reset[v]   = (flit[c].tail & ~single) | (single & credit);
                e.ovc_alloc[v]   = e.ovc_grant[v] & ~single;
                e.ovc_release[v] = e.ivc_reset[v] & ~single;
                e.single_flit[v] = single;
            end
        end
        return e;
    endfunction

    function automatic ssa_ctrl_t expect_ctrl(input int p);
        ssa_vc_evt_t in_e;
        ssa_vc_evt_t out_e;
        ssa_ctrl_t   x;
        port_idx_t   ss;
        in_e = ref_evt(p);
        ss = opposite_port(p);
        if (ss == PORT_NONE) begin
            out_e = '0;
        end else begin
            out_e = ref_evt(int'(ss));
        end
        x = '0;
        x.ovc_is_allocated          = out_e.ovc_alloc;
        x.ovc_is_released           = out_e.ovc_release;
        x.buff_space_decreased      = out_e.sw_grant;
        x.ivc_num_getting_sw_grant  = in_e.sw_grant;
        x.ivc_num_getting_ovc_grant = in_e.ovc_grant;
        x.ivc_reset                 = in_e.ivc_reset;
        x.ivc_single_flit_pck       = in_e.single_flit;
        for (int v = 0; v < NUM_VC; v++) begin
            x.ivc_granted_ovc_num[v] = in_e.ovc_grant[v] ? vc_vec_t'(1 << v) : '0;
        end
        x.ssa_flit_wr = flit_wr_exp[p];
        return x;
    endfunction

    task automatic check_ctrl(input int p, input ssa_ctrl_t got, input ssa_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t port %0d bundle got %h expected %h", $time, p, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_all();
        ssa_ctrl_t   got;
        ssa_ctrl_t   exp;
        ssa_vc_evt_t e;
        port_idx_t   ss;
        for (int p = 0; p < NUM_PORTS; p++) begin
            got = ssa_ctrl[p];
            exp = expect_ctrl(p);
            check_bit($sformatf("port %0d flit write", p), got.ssa_flit_wr, exp.ssa_flit_wr);
            got.ssa_flit_wr = 1'b0;
            exp.ssa_flit_wr = 1'b0;
            check_ctrl(p, got, exp);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            ss = opposite_port(p);
            e = (ss == PORT_NONE) ? ssa_vc_evt_t'(0) : ref_evt(int'(ss));
            flit_wr_exp[p] = |e.sw_grant; // lands next cycle
        end
    endtask

    // polls land on odd ns and clock edges on even ns
    task automatic wait_rise();
        int waited;
        waited = 0;
        while (clk !== 1'b0 && waited < POLL_LIMIT) begin
            #2;
            waited++;
        end
        while (clk !== 1'b1 && waited < POLL_LIMIT) begin
            #2;
            waited++;
        end
        if (waited >= POLL_LIMIT) begin
            $display("timeout: no rising clock edge seen at %0t", $time);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    task automatic next_cycle();
        wait_rise();
        #1; // inputs change 2 ns after the edge
    endtask

    task automatic finish_cycle();
        #7;
        check_all();
    endtask

    task automatic idle_inputs();
        for (int c = 0; c < NUM_PORTS; c++) begin
            flit[c]      = '0;
            ovc_avail[c] = '0;
            ovc_full[c]  = '0;
            for (int v = 0; v < NUM_VC; v++) begin
                ivc_info[c][v] = '0;
            end
        end
        flit_wr     = '0;
        sw_granted  = '0;
        ovc_granted = '0;
    endtask

    task automatic drive_flit(input int c, input int v, input logic hdr, input logic tail,
                              input port_idx_t dst);
        flit[c].hdr      = hdr;
        flit[c].tail     = tail;
        flit[c].vc       = vc_vec_t'(1 << v);
        flit[c].dst_port = dst;
        flit[c].payload  = $random(seed);
        flit_wr[c]       = 1'b1;
    endtask

    task automatic hdr_east_to_west();
        drive_flit(1, 0, 1'b1, 1'b0, PORT_WEST);
        ovc_avail[3] = 2'b01;
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic test_reset_idle();
        start_test();
        hdr_east_to_west(); // bypass strobes during reset must not leak into flit write
        for (int i = 0; i < 8; i++) begin
            wait_rise();
        end
        #1;
        rst_n = 1'b1;
        idle_inputs();
        finish_cycle();
        next_cycle();
        finish_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_ctrl(p, ssa_ctrl[p], ssa_ctrl_t'(0)); // everything quiet
        end
        end_test("reset idle");
    endtask

    task automatic test_header_straight();
        start_test();
        next_cycle();
        hdr_east_to_west();
        finish_cycle();
        check_bit("east sw grant", ssa_ctrl[1].ivc_num_getting_sw_grant[0], 1'b1);
        check_bit("east ovc grant", ssa_ctrl[1].ivc_num_getting_ovc_grant[0], 1'b1);
        check_bit("east granted ovc", ssa_ctrl[1].ivc_granted_ovc_num[0][0], 1'b1);
        check_bit("west ovc allocated", ssa_ctrl[3].ovc_is_allocated[0], 1'b1);
        check_bit("west credit", ssa_ctrl[3].buff_space_decreased[0], 1'b1);
        check_bit("west flit write early", ssa_ctrl[3].ssa_flit_wr, 1'b0);
        next_cycle();
        idle_inputs();
        finish_cycle();
        check_bit("west flit write", ssa_ctrl[3].ssa_flit_wr, 1'b1);
        next_cycle();
        finish_cycle();
        check_bit("west flit write low again", ssa_ctrl[3].ssa_flit_wr, 1'b0);
        end_test("header straight");
    endtask

    task automatic test_blocked();
        start_test();
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            idle_inputs();
            hdr_east_to_west();
            case (k)
                0:       sw_granted[1] = 1'b1;  // input owned by switch allocator
                1:       ovc_granted[3] = 1'b1; // west output already granted
                default: ivc_info[1][0].ivc_req = 1'b1;
            endcase
            finish_cycle();
            check_bit("blocked sw grant", ssa_ctrl[1].ivc_num_getting_sw_grant[0], 1'b0);
            check_bit("blocked allocate", ssa_ctrl[3].ovc_is_allocated[0], 1'b0);
        end
        next_cycle();
        idle_inputs();
        finish_cycle();
        end_test("blocked");
    endtask

    task automatic test_body_tail();
        start_test();
        next_cycle();
        idle_inputs();
        ivc_info[2][1] = '{ivc_req: 1'b0, ovc_is_assigned: 1'b1, assigned_ovc: 2'b10,
                           dest_port: PORT_SOUTH};
        drive_flit(2, 1, 1'b0, 1'b0, PORT_LOCAL); // dst is ignored on body flits
        finish_cycle();
        check_bit("body credit", ssa_ctrl[4].buff_space_decreased[1], 1'b1);
        check_bit("body no reset", ssa_ctrl[2].ivc_reset[1], 1'b0);
        next_cycle();
        flit[2].tail = 1'b1;
        finish_cycle();
        check_bit("tail credit", ssa_ctrl[4].buff_space_decreased[1], 1'b1);
        check_bit("tail reset", ssa_ctrl[2].ivc_reset[1], 1'b1);
        check_bit("tail release", ssa_ctrl[4].ovc_is_released[1], 1'b1);
        next_cycle();
        ovc_full[4] = 2'b10;
        finish_cycle();
        check_bit("full no credit", ssa_ctrl[4].buff_space_decreased[1], 1'b0);
        check_bit("full no reset", ssa_ctrl[2].ivc_reset[1], 1'b0);
        next_cycle();
        idle_inputs();
        finish_cycle();
        end_test("body tail");
    endtask

    task automatic test_single_flit();
        start_test();
        next_cycle();
        idle_inputs();
        drive_flit(4, 1, 1'b1, 1'b1, PORT_NORTH);
        ovc_avail[2] = 2'b10;
        finish_cycle();
        check_bit("single reset", ssa_ctrl[4].ivc_reset[1], 1'b1);
        check_bit("single flag", ssa_ctrl[4].ivc_single_flit_pck[1], 1'b1);
        check_bit("single credit", ssa_ctrl[2].buff_space_decreased[1], 1'b1);
        check_bit("single no allocate", ssa_ctrl[2].ovc_is_allocated[1], 1'b0);
        check_bit("single no release", ssa_ctrl[2].ovc_is_released[1], 1'b0);
        next_cycle();
        idle_inputs();
        finish_cycle();
        end_test("single flit");
    endtask

    task automatic test_no_bypass();
        start_test();
        next_cycle();
        idle_inputs();
        drive_flit(1, 0, 1'b1, 1'b0, PORT_NORTH); // turning header
        ovc_avail[3] = 2'b11;
        finish_cycle();
        check_bit("turn no sw grant", ssa_ctrl[1].ivc_num_getting_sw_grant[0], 1'b0);
        next_cycle();
        idle_inputs();
        drive_flit(0, 1, 1'b1, 1'b0, PORT_EAST);
        for (int p = 0; p < NUM_PORTS; p++) begin
            ovc_avail[p] = '1;
        end
        finish_cycle();
        check_bit("local no sw grant", ssa_ctrl[0].ivc_num_getting_sw_grant[1], 1'b0);
        check_bit("local no ovc grant", ssa_ctrl[0].ivc_num_getting_ovc_grant[1], 1'b0);
        next_cycle();
        idle_inputs();
        finish_cycle();
        end_test("no bypass");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        flit_wr_exp = '0;
        rst_n       = 1'b0;
        idle_inputs();
        #1;
        test_reset_idle();
        test_header_straight();
        test_blocked();
        test_body_tail();
        test_single_flit();
        test_no_bypass();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/ssa_pkg.sv
hdl/ssa_vc_ctrl.sv
hdl/ssa_in_port.sv
hdl/ssa_out_collect.sv
hdl/ssa_allocator.sv
verif/ssa_tb.sv
